// ==== common/pe_macros.svh ====
`ifndef PE_MACROS_SVH
`define PE_MACROS_SVH

// number of lanes in one row slice of the array.
`define PE_ROW 4

// width of one signed activation or weight operand.
`define PE_OPDW 8

// width of one lane product, wide enough for a full 8x8 signed multiply.
`define PE_ASUMDW 16

// the low half of a sum word, which is also the whole word in 16-bit mode.
`define PE_DWD 16

// width of one stored partial sum.
`define PE_PSUMDW 32

`endif

// ==== common/pe_data_pkg.sv ====
`include "pe_macros.svh"

package pe_data_pkg;

    localparam int LANEW = $clog2(`PE_ROW);

    typedef logic [LANEW-1:0] lane_t;

    typedef logic signed [`PE_OPDW-1:0] opnd_t;

    typedef struct packed {
        opnd_t a;
        opnd_t b;
    } op_pair_t;

    typedef op_pair_t [`PE_ROW-1:0] op_vec_t;

    typedef logic signed [`PE_ASUMDW-1:0] prod_t;
    typedef prod_t [`PE_ROW-1:0] prod_vec_t;

    typedef logic signed [`PE_PSUMDW-1:0] psum_t;
    typedef psum_t [`PE_ROW-1:0] psum_vec_t;

    // in 16-bit mode only the low half carries the value.
    typedef struct packed {
        logic [`PE_PSUMDW-`PE_DWD-1:0] pad;
        logic signed [`PE_DWD-1:0]     val;
    } psum_d16_t;

    typedef union packed {
        logic signed [`PE_PSUMDW-1:0] d32;
        psum_d16_t                    d16;
    } psum_word_u;

    // mode is 0 for 16-bit and 1 for 32-bit words.
    typedef struct packed {
        lane_t                 lane;
        logic                  mode;
        logic [`PE_PSUMDW-1:0] data;
    } psum_beat_t;

endpackage

// ==== common/pe_ctl_pkg.sv ====
package pe_ctl_pkg;

    import pe_data_pkg::*;

    typedef enum logic {
        D16 = 1'b0,
        D32 = 1'b1
    } psum_mode_e;

    // control for the accumulate, shift and saturate step.
    typedef struct packed {
        logic       resetsum;
        logic       psumread;
        logic [1:0] sht_num;
        psum_mode_e psum_mode;
    } ss_ctl_t;

    // control that travels with the sums towards the drain.
    typedef struct packed {
        logic       write;
        psum_mode_e psum_mode;
    } pp_ctl_t;

    typedef struct packed {
        op_vec_t   op;
        psum_vec_t preload;
        ss_ctl_t   ssctl;
        logic      write;
    } cmd_t;

    // the word handed from the multiply stage to the sum stage.
    typedef struct packed {
        prod_vec_t prod;
        psum_vec_t preload;
        ss_ctl_t   ssctl;
        pp_ctl_t   ppctl;
    } ms_pipe_t;

endpackage

// ==== design/mult_stage.sv ====
`timescale 1ns/1ns
`include "pe_macros.svh"

module mult_stage
    import pe_data_pkg::*, pe_ctl_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,

    input  cmd_t     i_cmd,
    input  logic     i_cmd_rdy,
    output logic     o_cmd_ack,

    output ms_pipe_t o_pipe,
    output logic     o_pipe_rdy,
    input  logic     i_pipe_ack
);

    logic      run_q;
    logic      pipe_rdy_q;
    logic      take;
    prod_vec_t prod_w;
    ms_pipe_t  pipe_q;

    // accept unless a held word is still waiting for the sum stage.
    assign o_cmd_ack = run_q && !(pipe_rdy_q && !i_pipe_ack);
    assign take      = i_cmd_rdy && o_cmd_ack;

    assign o_pipe     = pipe_q;
    assign o_pipe_rdy = pipe_rdy_q;

    // both operands are signed, so each product is a full signed result.
    always_comb begin
        for (int i = 0; i < `PE_ROW; i++) begin
            prod_w[i] = i_cmd.op[i].a * i_cmd.op[i].b;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_q      <= 1'b0;
            pipe_rdy_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (take) begin
                pipe_rdy_q <= 1'b1;
            end else if (i_pipe_ack) begin
                pipe_rdy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            pipe_q.prod            <= prod_w;
            pipe_q.preload         <= i_cmd.preload;
            pipe_q.ssctl           <= i_cmd.ssctl;
            pipe_q.ppctl.write     <= i_cmd.write;
            pipe_q.ppctl.psum_mode <= i_cmd.ssctl.psum_mode;
        end
    end

endmodule

// ==== accum/sum_stage.sv ====
`timescale 1ns/1ns
`include "pe_macros.svh"

module sum_stage
    import pe_data_pkg::*, pe_ctl_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,

    input  ms_pipe_t  i_pipe,
    input  logic      i_pipe_rdy,
    output logic      o_pipe_ack,

    output psum_vec_t o_sum,
    output pp_ctl_t   o_ppctl,
    output logic      o_sum_rdy,
    input  logic      i_sum_ack
);

    localparam logic [`PE_PSUMDW-1:0] MAX16 = 32'h0000_7fff;
    localparam logic [`PE_PSUMDW-1:0] MIN16 = 32'h0000_8000;
    localparam logic [`PE_PSUMDW-1:0] MAX32 = 32'h7fff_ffff;
    localparam logic [`PE_PSUMDW-1:0] MIN32 = 32'h8000_0000;

    logic      run_q;
    logic      take;
    logic      d16;
    ss_ctl_t   ctl;
    psum_vec_t sum_q;
    psum_vec_t sum_w;
    pp_ctl_t   ppctl_q;

    psum_t operand [`PE_ROW];
    psum_t shifted [`PE_ROW];
    logic  op_sign [`PE_ROW];
    logic  top_bit [`PE_ROW];
    logic  ovf     [`PE_ROW];
    logic  unf     [`PE_ROW];

    assign ctl = i_pipe.ssctl;
    assign d16 = (ctl.psum_mode == D16);

    // a write result blocks new words until the drain has taken it.
    assign o_pipe_ack = run_q && !(o_sum_rdy && !i_sum_ack);
    assign take       = i_pipe_rdy && o_pipe_ack;

    assign o_sum_rdy = ppctl_q.write;
    assign o_sum     = sum_q;
    assign o_ppctl   = ppctl_q;

    always_comb begin
        for (int i = 0; i < `PE_ROW; i++) begin
            if (ctl.resetsum) begin
                operand[i] = '0;
            end else if (ctl.psumread) begin
                operand[i] = i_pipe.preload[i];
            end else begin
                operand[i] = sum_q[i];
            end

            shifted[i] = (operand[i] + i_pipe.prod[i]) << ctl.sht_num;

            // the sign sits at bit 15 or bit 31 depending on the mode.
            op_sign[i] = d16 ? operand[i][`PE_DWD-1] : operand[i][`PE_PSUMDW-1];
            top_bit[i] = d16 ? shifted[i][`PE_DWD-1] : shifted[i][`PE_PSUMDW-1];

            ovf[i] = !op_sign[i] && !i_pipe.prod[i][`PE_ASUMDW-1] && top_bit[i];
            unf[i] = op_sign[i] && i_pipe.prod[i][`PE_ASUMDW-1] && !top_bit[i];

            if (ovf[i]) begin
                sum_w[i] = d16 ? MAX16 : MAX32;
            end else if (unf[i]) begin
                sum_w[i] = d16 ? MIN16 : MIN32;
            end else begin
                sum_w[i][`PE_DWD-1:0]           = shifted[i][`PE_DWD-1:0];
                sum_w[i][`PE_PSUMDW-1:`PE_DWD] = d16 ? '0 : shifted[i][`PE_PSUMDW-1:`PE_DWD];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_q   <= 1'b0;
            sum_q   <= '0;
            ppctl_q <= '0;
        end else begin
            run_q <= 1'b1;
            if (take) begin
                sum_q   <= sum_w;
                ppctl_q <= i_pipe.ppctl;
            end else if (o_sum_rdy && i_sum_ack) begin
                // the sums stay, only the request to write them is retired.
                ppctl_q.write <= 1'b0;
            end
        end
    end

endmodule

// ==== design/psum_drain.sv ====
`timescale 1ns/1ns
`include "pe_macros.svh"

module psum_drain
    import pe_data_pkg::*, pe_ctl_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,

    input  psum_vec_t  i_sum,
    input  pp_ctl_t    i_ppctl,
    input  logic       i_sum_rdy,
    output logic       o_sum_ack,

    output psum_beat_t o_beat,
    output logic       o_beat_rdy,
    input  logic       i_beat_ack
);

    logic       run_q;
    logic       busy_q;
    lane_t      lane_q;
    psum_vec_t  sum_q;
    psum_mode_e mode_q;
    psum_word_u word;
    logic       take;
    logic       last;

    // only an idle drain takes a new vector.
    assign o_sum_ack = run_q && !busy_q;
    assign take      = i_sum_rdy && i_ppctl.write && o_sum_ack;

    assign o_beat_rdy = busy_q;
    assign last       = (lane_q == lane_t'(`PE_ROW - 1));
    assign word       = sum_q[lane_q];

    always_comb begin
        o_beat.lane = lane_q;
        o_beat.mode = mode_q;
        if (mode_q == D16) begin
            o_beat.data = {{(`PE_PSUMDW-`PE_DWD){word.d16.val[`PE_DWD-1]}}, word.d16.val};
        end else begin
            o_beat.data = word.d32;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_q  <= 1'b0;
            busy_q <= 1'b0;
            lane_q <= '0;
        end else begin
            run_q <= 1'b1;
            if (take) begin
                busy_q <= 1'b1;
                lane_q <= '0;
            end else if (busy_q && i_beat_ack) begin
                // step to the next lane, going idle after the last one.
                if (last) begin
                    busy_q <= 1'b0;
                    lane_q <= '0;
                end else begin
                    lane_q <= lane_q + lane_t'(1);
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            sum_q  <= i_sum;
            mode_q <= i_ppctl.psum_mode;
        end
    end

endmodule

// ==== design/pe_row_top.sv ====
`timescale 1ns/1ns

module pe_row_top
    import pe_data_pkg::*, pe_ctl_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,

    input  cmd_t       i_cmd,
    input  logic       i_cmd_rdy,
    output logic       o_cmd_ack,

    output psum_beat_t o_beat,
    output logic       o_beat_rdy,
    input  logic       i_beat_ack
);

    // multiply stage to sum stage.
    ms_pipe_t  ms_pipe;
    logic      ms_rdy;
    logic      ms_ack;

    // sum stage to drain.
    psum_vec_t ss_sum;
    pp_ctl_t   ss_ppctl;
    logic      ss_rdy;
    logic      ss_ack;

    mult_stage u_mult (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_cmd      (i_cmd),
        .i_cmd_rdy  (i_cmd_rdy),
        .o_cmd_ack  (o_cmd_ack),
        .o_pipe     (ms_pipe),
        .o_pipe_rdy (ms_rdy),
        .i_pipe_ack (ms_ack)
    );

    sum_stage u_sum (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_pipe     (ms_pipe),
        .i_pipe_rdy (ms_rdy),
        .o_pipe_ack (ms_ack),
        .o_sum      (ss_sum),
        .o_ppctl    (ss_ppctl),
        .o_sum_rdy  (ss_rdy),
        .i_sum_ack  (ss_ack)
    );

    psum_drain u_drain (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_sum      (ss_sum),
        .i_ppctl    (ss_ppctl),
        .i_sum_rdy  (ss_rdy),
        .o_sum_ack  (ss_ack),
        .o_beat     (o_beat),
        .o_beat_rdy (o_beat_rdy),
        .i_beat_ack (i_beat_ack)
    );

endmodule

// ==== sim/pe_row_properties.sv ====
`timescale 1ns/1ns
`include "pe_macros.svh"

module pe_row_properties
    import pe_data_pkg::*, pe_ctl_pkg::*;
(
    input logic       i_clk,
    input logic       i_rst_n,
    input logic       o_cmd_ack,
    input logic       ms_rdy,
    input logic       ms_ack,
    input ms_pipe_t   ms_pipe,
    input logic       ss_rdy,
    input logic       ss_ack,
    input psum_vec_t  ss_sum,
    input psum_beat_t o_beat,
    input logic       o_beat_rdy,
    input logic       i_beat_ack
);

    // a held request keeps its data until it is taken.
    a_pipe_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ms_rdy && !ms_ack |=> ms_rdy && $stable(ms_pipe))
        else $error("pipe word changed before it was taken");

    a_sum_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ss_rdy && !ss_ack |=> ss_rdy && $stable(ss_sum))
        else $error("sum vector changed before it was taken");

    a_beat_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_beat_rdy && !i_beat_ack |=> o_beat_rdy && $stable(o_beat))
        else $error("beat changed before it was taken");

    a_reset: assert property (@(negedge i_clk)
        !i_rst_n |-> !o_cmd_ack && !ms_rdy && !ms_ack && !ss_rdy && !ss_ack && !o_beat_rdy)
        else $error("handshake output high during reset");

    a_lane_step: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_beat_rdy && i_beat_ack && o_beat.lane != lane_t'(`PE_ROW - 1)
        |=> o_beat_rdy && o_beat.lane == $past(o_beat.lane) + lane_t'(1))
        else $error("beat lane did not step by one");

    a_lane_wrap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_beat_rdy) |-> o_beat.lane == '0)
        else $error("vector did not start at lane zero");

endmodule

bind pe_row_top pe_row_properties u_props (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .o_cmd_ack  (o_cmd_ack),
    .ms_rdy     (ms_rdy),
    .ms_ack     (ms_ack),
    .ms_pipe    (ms_pipe),
    .ss_rdy     (ss_rdy),
    .ss_ack     (ss_ack),
    .ss_sum     (ss_sum),
    .o_beat     (o_beat),
    .o_beat_rdy (o_beat_rdy),
    .i_beat_ack (i_beat_ack)
);

// ==== sim/pe_row_tb.sv ====
`timescale 1ns/1ns
`include "pe_macros.svh"

module pe_row_tb
    import pe_data_pkg::*, pe_ctl_pkg::*;
();

    localparam int PERIOD  = 100;
    localparam int NRAND   = 200;
    localparam int NDIR    = 30;
    localparam int TIMEOUT = ((NRAND + NDIR) * (`PE_ROW * 8 + 8) + 100) * PERIOD;

    logic       i_clk;
    logic       i_rst_n;
    cmd_t       i_cmd;
    logic       i_cmd_rdy;
    logic       o_cmd_ack;
    psum_beat_t o_beat;
    logic       o_beat_rdy;
    logic       i_beat_ack;

    logic [15:0] lfsr_q;
    logic        cmd_taken;
    int          value_errors;
    int          other_errors;
    psum_t       acc [`PE_ROW];
    psum_beat_t  exp_q [$];
    cmd_t        cmd_q [$];

    pe_row_top dut0 (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_cmd      (i_cmd),
        .i_cmd_rdy  (i_cmd_rdy),
        .o_cmd_ack  (o_cmd_ack),
        .o_beat     (o_beat),
        .o_beat_rdy (o_beat_rdy),
        .i_beat_ack (i_beat_ack)
    );

    always #(PERIOD / 2) i_clk = ~i_clk;

    // taps 16, 14, 13 and 11, one step per bit.
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, act, exp);
            value_errors++;
        end
    endtask

    function automatic cmd_t make_cmd(input logic [7:0] a, input logic [7:0] b,
                                      input logic [31:0] pre, input logic rs,
                                      input logic pr, input logic [1:0] sht,
                                      input psum_mode_e mode, input logic wr);
        cmd_t c;
        for (int i = 0; i < `PE_ROW; i++) begin
            c.op[i].a     = a;
            c.op[i].b     = b;
            c.preload[i]  = pre;
        end
        c.ssctl.resetsum  = rs;
        c.ssctl.psumread  = pr;
        c.ssctl.sht_num   = sht;
        c.ssctl.psum_mode = mode;
        c.write           = wr;
        return c;
    endfunction

    function automatic cmd_t random_cmd();
        cmd_t c;
        for (int i = 0; i < `PE_ROW; i++) begin
            c.op[i].a    = 8'(rand_bits(8));
            c.op[i].b    = 8'(rand_bits(8));
            c.preload[i] = rand_bits(32);
        end
        c.ssctl.resetsum  = (rand_bits(3) == 0);
        c.ssctl.psumread  = (rand_bits(3) == 0);
        c.ssctl.sht_num   = 2'(rand_bits(2));
        c.ssctl.psum_mode = psum_mode_e'(1'(rand_bits(1)));
        c.write           = 1'(rand_bits(1));
        return c;
    endfunction

    // pick the operand, add, shift, then clamp at the mode's sign bit.
    task automatic model_cmd(input cmd_t c);
        logic signed [15:0] p;
        psum_t              p32;
        psum_t              opnd;
        psum_t              shf;
        psum_t              res;
        logic               d16;
        logic               os;
        logic               tb;
        psum_beat_t         b;
        d16 = (c.ssctl.psum_mode == D16);
        for (int i = 0; i < `PE_ROW; i++) begin
            p   = c.op[i].a * c.op[i].b;
            p32 = p;
            if (c.ssctl.resetsum) opnd = '0;
            else if (c.ssctl.psumread) opnd = c.preload[i];
            else opnd = acc[i];
            shf = (opnd + p32) << c.ssctl.sht_num;
            os  = d16 ? opnd[15] : opnd[31];
            tb  = d16 ? shf[15] : shf[31];
            if (!os && !p[15] && tb) begin
                res = d16 ? 32'h0000_7fff : 32'h7fff_ffff;
            end else if (os && p[15] && !tb) begin
                res = d16 ? 32'h0000_8000 : 32'h8000_0000;
            end else begin
                res = d16 ? {16'h0, shf[15:0]} : shf;
            end
            acc[i] = res;
            if (c.write) begin
                b.lane = lane_t'(i);
                b.mode = c.ssctl.psum_mode;
                b.data = d16 ? {{16{res[15]}}, res[15:0]} : res;
                exp_q.push_back(b);
            end
        end
    endtask

    // drive on the falling edge, sample a quarter period later.
    // a command seen with ack here transfers on the next rising edge,
    // so rdy stays up until the falling edge after it.
    task automatic step_cycle();
        psum_beat_t e;
        @(negedge i_clk);
        if (cmd_taken) begin
            i_cmd_rdy = 1'b0;
            cmd_taken = 1'b0;
        end
        if (!i_cmd_rdy && cmd_q.size() > 0 && rand_bits(2) != 0) begin
            i_cmd     = cmd_q.pop_front();
            i_cmd_rdy = 1'b1;
        end
        i_beat_ack = (rand_bits(2) != 0);
        #(PERIOD / 4);
        if (i_cmd_rdy && o_cmd_ack) begin
            model_cmd(i_cmd);
            cmd_taken = 1'b1;
        end
        if (o_beat_rdy && i_beat_ack) begin
            if (exp_q.size() == 0) begin
                $display("a beat for lane %0d came out with no beat expected", o_beat.lane);
                other_errors++;
            end else begin
                e = exp_q.pop_front();
                check_value("o_beat.lane", 32'(o_beat.lane), 32'(e.lane));
                check_value("o_beat.mode", 32'(o_beat.mode), 32'(e.mode));
                check_value("o_beat.data", o_beat.data, e.data);
            end
        end
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout: the beats did not finish within %0d ns", TIMEOUT);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        i_clk        = 1'b0;
        i_rst_n      = 1'b0;
        i_cmd        = '0;
        i_cmd_rdy    = 1'b0;
        i_beat_ack   = 1'b0;
        lfsr_q       = 16'd36722;
        cmd_taken    = 1'b0;
        value_errors = 0;
        other_errors = 0;
        for (int i = 0; i < `PE_ROW; i++) begin
            acc[i] = '0;
        end

        // the first write after reset must see sums that start from zero.
        cmd_q.push_back(make_cmd(8'd1, 8'd2, 32'd0, 1'b0, 1'b0, 2'd0, D32, 1'b1));
        cmd_q.push_back(make_cmd(8'd3, 8'd4, 32'd0, 1'b1, 1'b0, 2'd0, D32, 1'b0));
        cmd_q.push_back(make_cmd(8'd5, 8'd6, 32'd0, 1'b0, 1'b0, 2'd0, D32, 1'b1));
        cmd_q.push_back(make_cmd(8'd7, -8'sd8, 32'd0, 1'b0, 1'b0, 2'd0, D32, 1'b1));
        cmd_q.push_back(make_cmd(8'd2, 8'd3, 32'd1000, 1'b0, 1'b1, 2'd0, D32, 1'b1));
        for (int s = 0; s < 4; s++) begin
            cmd_q.push_back(make_cmd(8'd9, 8'd9, 32'h0012_3456, 1'b0, 1'b1, 2'(s), D32, 1'b1));
            cmd_q.push_back(make_cmd(8'd2, -8'sd3, 32'd5, 1'b0, 1'b1, 2'(s), D32, 1'b1));
            cmd_q.push_back(make_cmd(8'd100, 8'd50, 32'h0000_1234, 1'b0, 1'b1, 2'(s), D16,
                                     1'b1));
        end
        cmd_q.push_back(make_cmd(8'd127, 8'd127, 32'd0, 1'b1, 1'b0, 2'd0, D16, 1'b0));
        cmd_q.push_back(make_cmd(8'd127, 8'd127, 32'd0, 1'b0, 1'b0, 2'd0, D16, 1'b1));
        cmd_q.push_back(make_cmd(8'd127, 8'd127, 32'd0, 1'b0, 1'b0, 2'd0, D16, 1'b1));
        cmd_q.push_back(make_cmd(-8'sd128, 8'd127, 32'd0, 1'b1, 1'b0, 2'd0, D16, 1'b0));
        cmd_q.push_back(make_cmd(-8'sd128, 8'd127, 32'd0, 1'b0, 1'b0, 2'd0, D16, 1'b1));
        cmd_q.push_back(make_cmd(-8'sd128, 8'd127, 32'd0, 1'b0, 1'b0, 2'd0, D16, 1'b1));
        cmd_q.push_back(make_cmd(8'd127, 8'd127, 32'h7fff_0000, 1'b0, 1'b1, 2'd0, D32, 1'b1));
        cmd_q.push_back(make_cmd(8'd127, 8'd127, 32'd0, 1'b0, 1'b0, 2'd1, D32, 1'b1));
        cmd_q.push_back(make_cmd(-8'sd128, 8'd127, 32'h8000_1000, 1'b0, 1'b1, 2'd0, D32, 1'b1));
        for (int n = 0; n < NRAND; n++) begin
            cmd_q.push_back(random_cmd());
        end

        repeat (4) @(posedge i_clk);
        #(PERIOD / 4);
        check_value("o_beat_rdy", 32'(o_beat_rdy), 32'h0);
        check_value("o_cmd_ack", 32'(o_cmd_ack), 32'h0);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        repeat (3) begin
            @(negedge i_clk);
            check_value("o_beat_rdy", 32'(o_beat_rdy), 32'h0);
        end

        while (cmd_q.size() > 0 || i_cmd_rdy || exp_q.size() > 0) begin
            step_cycle();
        end
        // a few idle cycles catch any extra beat.
        repeat (20) step_cycle();

        $display("errors: %0d value mismatches, %0d other failures", value_errors,
                 other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== pe_row.f ====
+incdir+common
common/pe_data_pkg.sv
common/pe_ctl_pkg.sv
design/mult_stage.sv
accum/sum_stage.sv
design/psum_drain.sv
design/pe_row_top.sv
sim/pe_row_properties.sv
sim/pe_row_tb.sv

// ==== Makefile ====
TOP := pe_row_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f pe_row.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Some tests failed" sim.log; then exit 1; fi
	@grep -q "All tests passed" sim.log

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f pe_row.f

clean:
	rm -rf obj_dir sim.log
